// File: rtl/coll_defines.svh
`ifndef COLL_DEFINES_SVH
`define COLL_DEFINES_SVH

// ***********************************************************
// collector sizing.
// ***********************************************************
`define COLL_DATA_W    8    // element width in bits.
`define COLL_DEPTH     4    // elements held per channel fifo.
`define COLL_CNT_W     8    // popped-element counter width.

// ***********************************************************
// wishbone port.
// ***********************************************************
`define COLL_WB_ADR_W  2    // word address width.
`define COLL_WB_DAT_W  32   // bus data width.

`define COLL_ADR_POP   0    // read pops one tagged element.
`define COLL_ADR_COUNT 1    // per-channel pop counts, write clears.

`endif

// File: rtl/coll_pkg.sv
`default_nettype none

`include "coll_defines.svh"

package coll_pkg;

    // ***********************************************************
    // plain vector types.
    // ***********************************************************
    typedef logic [`COLL_DATA_W-1:0]   data_t;     // one element value.
    typedef logic                      chan_t;     // source channel index.
    typedef logic [`COLL_CNT_W-1:0]    cnt_t;      // pop counter, wraps.
    typedef logic [`COLL_WB_ADR_W-1:0] wb_adr_t;   // bus word address.
    typedef logic [`COLL_WB_DAT_W-1:0] wb_dat_t;   // bus data word.

    // ***********************************************************
    // grouped signals.
    // ***********************************************************
    typedef struct packed {
        chan_t chan;                               // channel the element came from.
        data_t data;                               // element payload.
    } tagged_elem_t;

    typedef struct packed {
        logic    cyc;                              // bus cycle in progress.
        logic    stb;                              // strobe for this transfer.
        logic    we;                               // write when high.
        wb_adr_t adr;                              // word address.
        wb_dat_t dat;                              // write data.
    } wb_req_t;

    typedef struct packed {
        logic    ack;                              // one-cycle acknowledge.
        wb_dat_t dat;                              // read data, valid with ack.
    } wb_rsp_t;

    typedef enum logic {
        WB_IDLE,                                   // waiting for a strobe.
        WB_ACK                                     // acknowledge cycle.
    } wb_state_e;

endpackage

`default_nettype wire

// File: rtl/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
    parameter int elem_width = 8,
    parameter int depth      = 4
) (
    input  logic                  clk_i,
    input  logic                  arst_ni,

    input  logic [elem_width-1:0] elem_in_i,
    input  logic                  elem_in_valid_i,
    output logic                  elem_in_ready_o,

    output logic [elem_width-1:0] elem_out_o,
    output logic                  elem_out_valid_o,
    input  logic                  elem_out_ready_i
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;   // storage index width.
    localparam int cnt_w = $clog2(depth + 1);                 // holds 0 to depth.

    logic [elem_width-1:0] mem [depth];                       // circular storage.

    logic [ptr_w-1:0] wr_ptr_q;                               // next slot to write.
    logic [ptr_w-1:0] rd_ptr_q;                               // oldest stored slot.
    logic [ptr_w-1:0] wr_ptr_nxt;
    logic [ptr_w-1:0] rd_ptr_nxt;
    logic [cnt_w-1:0] count_q;                                // stored elements.

    logic empty;
    logic full;
    logic push;
    logic pop;

    // ***********************************************************
    // handshake and fall-through.
    // ***********************************************************
    assign empty = (count_q == '0);
    assign full  = (count_q == cnt_w'(depth));

    assign elem_in_ready_o  = full ? elem_out_ready_i : 1'b1;    // full takes a write only on a read.
    assign elem_out_valid_o = empty ? elem_in_valid_i : 1'b1;    // empty passes input straight on.
    assign elem_out_o       = empty ? elem_in_i : mem[rd_ptr_q];

    assign push = elem_in_valid_i & elem_in_ready_o;
    assign pop  = elem_out_valid_o & elem_out_ready_i;

    assign wr_ptr_nxt = (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
    assign rd_ptr_nxt = (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;

    // ***********************************************************
    // pointers and count.
    // ***********************************************************
    always_ff @(posedge clk_i or negedge arst_ni) begin
        if (!arst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_nxt;
            if (pop) rd_ptr_q <= rd_ptr_nxt;                   // bypass moves both pointers together.
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;                   // idle or simultaneous push and pop.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= elem_in_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rr_stream_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_stream_arbiter
    import coll_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_ni,

    input  data_t        in0_data_i,
    input  logic         in0_valid_i,
    output logic         in0_ready_o,

    input  data_t        in1_data_i,
    input  logic         in1_valid_i,
    output logic         in1_ready_o,

    output tagged_elem_t out_elem_o,
    output logic         out_valid_o,
    input  logic         out_ready_i
);

    chan_t prio_q;       // channel favoured for the next grant.
    chan_t grant;        // channel selected this cycle.
    logic  fav_valid;    // favoured channel has data.
    logic  fire;         // output transfer.

    // ***********************************************************
    // grant selection.
    // ***********************************************************
    assign fav_valid = prio_q ? in1_valid_i : in0_valid_i;
    assign grant     = fav_valid ? prio_q : ~prio_q;     // fall back to the other channel.

    assign out_valid_o = in0_valid_i | in1_valid_i;
    assign out_elem_o  = '{chan: grant, data: (grant ? in1_data_i : in0_data_i)};

    assign in0_ready_o = out_ready_i & (grant == 1'b0);  // only the granted input sees ready.
    assign in1_ready_o = out_ready_i & (grant == 1'b1);

    assign fire = out_valid_o & out_ready_i;

    // ***********************************************************
    // round-robin priority.
    // ***********************************************************
    always_ff @(posedge clk_i or negedge arst_ni) begin
        if (!arst_ni) begin
            prio_q <= 1'b0;                              // channel 0 first out of reset.
        end else if (fire) begin
            prio_q <= ~grant;                            // next time favour the loser.
        end
    end

endmodule

`default_nettype wire

// File: rtl/wb_pop_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_defines.svh"

module wb_pop_port
    import coll_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_ni,

    input  wb_req_t      wb_req_i,
    output wb_rsp_t      wb_rsp_o,

    input  tagged_elem_t elem_i,
    input  logic         elem_valid_i,
    output logic         elem_ready_o
);

    wb_state_e  state_q;     // bus handshake state.
    wb_dat_t    rd_dat_q;    // read word returned with ack.
    wb_dat_t    rd_word;     // decoded read word.
    cnt_t [1:0] cnt_q;       // pops per channel, channel 1 in the upper byte.

    logic req;               // new request seen in idle.
    logic is_pop;            // address hits the pop register.
    logic is_count;          // address hits the count register.
    logic clr_cnt;           // write to the count register.

    // ***********************************************************
    // request decode.
    // ***********************************************************
    assign req      = (state_q == WB_IDLE) & wb_req_i.cyc & wb_req_i.stb;
    assign is_pop   = (wb_req_i.adr == wb_adr_t'(`COLL_ADR_POP));
    assign is_count = (wb_req_i.adr == wb_adr_t'(`COLL_ADR_COUNT));
    assign clr_cnt  = req & wb_req_i.we & is_count;

    // pop happens in the sampling cycle, data comes back with ack.
    assign elem_ready_o = req & ~wb_req_i.we & is_pop & elem_valid_i;

    always_comb begin
        rd_word = '0;                                        // empty pop and unmapped read zero.
        if (is_pop && elem_valid_i) begin
            rd_word[`COLL_WB_DAT_W-1]   = 1'b1;              // valid flag.
            rd_word[`COLL_DATA_W]       = elem_i.chan;       // source channel.
            rd_word[`COLL_DATA_W-1:0]   = elem_i.data;
        end else if (is_count) begin
            rd_word[2*`COLL_CNT_W-1:0] = cnt_q;
        end
    end

    // ***********************************************************
    // bus state machine.
    // ***********************************************************
    always_ff @(posedge clk_i or negedge arst_ni) begin
        if (!arst_ni) begin
            state_q <= WB_IDLE;
        end else begin
            case (state_q)
                WB_IDLE: begin
                    if (req) state_q <= WB_ACK;              // ack follows next cycle.
                end
                WB_ACK: begin
                    state_q <= WB_IDLE;                      // master drops stb with ack.
                end
                default: begin
                    state_q <= WB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req) begin
            rd_dat_q <= wb_req_i.we ? '0 : rd_word;          // writes return a zero word.
        end
    end

    assign wb_rsp_o = '{ack: (state_q == WB_ACK), dat: rd_dat_q};

    // ***********************************************************
    // per-channel pop counters.
    // ***********************************************************
    always_ff @(posedge clk_i or negedge arst_ni) begin
        if (!arst_ni) begin
            cnt_q <= '0;
        end else if (clr_cnt) begin
            cnt_q <= '0;                                     // any write clears both.
        end else if (elem_ready_o) begin
            cnt_q[elem_i.chan] <= cnt_q[elem_i.chan] + 1'b1; // wraps modulo 256.
        end
    end

endmodule

`default_nettype wire

// File: rtl/stream_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_defines.svh"

module stream_collector
    import coll_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_ni,

    input  data_t   in0_data_i,
    input  logic    in0_valid_i,
    output logic    in0_ready_o,

    input  data_t   in1_data_i,
    input  logic    in1_valid_i,
    output logic    in1_ready_o,

    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    data_t        fifo0_data;     // channel 0 head element.
    logic         fifo0_valid;
    logic         fifo0_ready;
    data_t        fifo1_data;     // channel 1 head element.
    logic         fifo1_valid;
    logic         fifo1_ready;

    tagged_elem_t arb_elem;       // merged tagged stream.
    logic         arb_valid;
    logic         arb_ready;      // one-cycle pop strobe from the bus side.

    // ***********************************************************
    // per-channel buffering.
    // ***********************************************************
    fifo #(
        .elem_width (`COLL_DATA_W),
        .depth      (`COLL_DEPTH)
    ) u_fifo0 (
        .clk_i            (clk_i),
        .arst_ni          (arst_ni),
        .elem_in_i        (in0_data_i),
        .elem_in_valid_i  (in0_valid_i),
        .elem_in_ready_o  (in0_ready_o),
        .elem_out_o       (fifo0_data),
        .elem_out_valid_o (fifo0_valid),
        .elem_out_ready_i (fifo0_ready)
    );

    fifo #(
        .elem_width (`COLL_DATA_W),
        .depth      (`COLL_DEPTH)
    ) u_fifo1 (
        .clk_i            (clk_i),
        .arst_ni          (arst_ni),
        .elem_in_i        (in1_data_i),
        .elem_in_valid_i  (in1_valid_i),
        .elem_in_ready_o  (in1_ready_o),
        .elem_out_o       (fifo1_data),
        .elem_out_valid_o (fifo1_valid),
        .elem_out_ready_i (fifo1_ready)
    );

    // ***********************************************************
    // merge and host port.
    // ***********************************************************
    rr_stream_arbiter u_arb (
        .clk_i       (clk_i),
        .arst_ni     (arst_ni),
        .in0_data_i  (fifo0_data),
        .in0_valid_i (fifo0_valid),
        .in0_ready_o (fifo0_ready),
        .in1_data_i  (fifo1_data),
        .in1_valid_i (fifo1_valid),
        .in1_ready_o (fifo1_ready),
        .out_elem_o  (arb_elem),
        .out_valid_o (arb_valid),
        .out_ready_i (arb_ready)
    );

    wb_pop_port u_wb (
        .clk_i        (clk_i),
        .arst_ni      (arst_ni),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .elem_i       (arb_elem),
        .elem_valid_i (arb_valid),
        .elem_ready_o (arb_ready)
    );

endmodule

`default_nettype wire

// File: tb/tb_stream_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "coll_defines.svh"

module tb_stream_collector
    import coll_pkg::*;
();

    localparam int ack_timeout   = 20;     // cycles allowed for a bus ack.
    localparam int ready_timeout = 20;     // cycles allowed for a stream ready.

    logic    clk;
    logic    arst_n;
    data_t   in0_data;
    logic    in0_valid;
    logic    in0_ready;
    data_t   in1_data;
    logic    in1_valid;
    logic    in1_ready;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    data_t   q0[$];                        // expected channel 0 contents.
    data_t   q1[$];                        // expected channel 1 contents.
    chan_t   prio;                         // modelled round-robin favourite.
    cnt_t    cnt0;                         // modelled pop counts.
    cnt_t    cnt1;
    int      value_errs;
    int      timeout_errs;

    stream_collector uut (
        .clk_i       (clk),
        .arst_ni     (arst_n),
        .in0_data_i  (in0_data),
        .in0_valid_i (in0_valid),
        .in0_ready_o (in0_ready),
        .in1_data_i  (in1_data),
        .in1_valid_i (in1_valid),
        .in1_ready_o (in1_ready),
        .wb_req_i    (wb_req),
        .wb_rsp_o    (wb_rsp)
    );

    always #50 clk = ~clk;                 // 100 ns period.

    // ***********************************************************
    // checking and bus helpers.
    // ***********************************************************
    task automatic expect_eq(input string sig, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            value_errs++;
            $display("Fail at %0t: %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (3) @(negedge clk);         // held for three cycles.
        arst_n = 1'b1;
        q0.delete();
        q1.delete();
        prio = 1'b0;                       // channel 0 favoured out of reset.
        cnt0 = '0;
        cnt1 = '0;
    endtask

    task automatic bus_access(input logic we, input wb_adr_t addr, input wb_dat_t wdat,
                              output wb_dat_t rdat);
        int   waited;
        logic acked;
        rdat   = '0;
        waited = 0;
        acked  = 1'b0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: addr, dat: wdat};
        while (!acked && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;            // registered data, stable here.
            end
        end
        wb_req.cyc = 1'b0;                     // stb drops inside the ack cycle.
        wb_req.stb = 1'b0;
        assert (acked) else begin
            timeout_errs++;
            $display("Error at %0t: no ack from the Wishbone slave within %0d cycles",
                     $time, ack_timeout);
        end
        if (acked) expect_eq("ack latency", 32'd1, waited);
        @(negedge clk);
        expect_eq("wb_rsp_o.ack after ack cycle", 32'd0, wb_rsp.ack);
    endtask

    task automatic wb_read(input wb_adr_t addr, output wb_dat_t rdat);
        bus_access(1'b0, addr, '0, rdat);
    endtask

    task automatic wb_write(input wb_adr_t addr, input wb_dat_t wdat);
        wb_dat_t unused;
        bus_access(1'b1, addr, wdat, unused);
    endtask

    task automatic push_elem(input chan_t ch, input data_t d);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        if (ch) begin
            in1_data  = d;
            in1_valid = 1'b1;
        end else begin
            in0_data  = d;
            in0_valid = 1'b1;
        end
        while (!accepted && waited < ready_timeout) begin
            #1;                                // let ready settle after the drive.
            if (ch ? in1_ready : in0_ready) accepted = 1'b1;
            @(negedge clk);                    // transfer took place on the posedge.
            waited++;
        end
        in0_valid = 1'b0;
        in1_valid = 1'b0;
        assert (accepted) else begin
            timeout_errs++;
            $display("Error at %0t: channel %0d never became ready for a push", $time, ch);
        end
        if (accepted) begin
            if (ch) q1.push_back(d);
            else q0.push_back(d);
        end
    endtask

    // pops one element and checks it against the queues and the round-robin rule.
    task automatic pop_and_check();
        wb_dat_t got;
        wb_dat_t exp;
        chan_t   ch;
        data_t   d;
        exp = '0;                              // empty collector reads zero.
        if (q0.size() != 0 || q1.size() != 0) begin
            if (prio) ch = (q1.size() != 0) ? 1'b1 : 1'b0;
            else ch = (q0.size() != 0) ? 1'b0 : 1'b1;
            if (ch) d = q1.pop_front();
            else d = q0.pop_front();
            exp  = {1'b1, 22'b0, ch, d};       // valid, channel, data.
            prio = ~ch;                        // the other channel goes next.
            if (ch) cnt1 = cnt1 + 1'b1;
            else cnt0 = cnt0 + 1'b1;
        end
        wb_read(`COLL_ADR_POP, got);
        expect_eq("wb_rsp_o.dat (pop)", exp, got);
    endtask

    task automatic check_counts();
        wb_dat_t got;
        wb_read(`COLL_ADR_COUNT, got);
        expect_eq("wb_rsp_o.dat (count)", {16'b0, cnt1, cnt0}, got);
    endtask

    // ***********************************************************
    // directed tests.
    // ***********************************************************
    task automatic idle_after_reset();
        expect_eq("wb_rsp_o.ack", 32'd0, wb_rsp.ack);
        expect_eq("in0_ready_o", 32'd1, in0_ready);
        expect_eq("in1_ready_o", 32'd1, in1_ready);
        pop_and_check();                       // nothing queued.
        check_counts();
    endtask

    task automatic single_channel_order();
        push_elem(1'b0, 8'h11);
        push_elem(1'b0, 8'h22);
        push_elem(1'b0, 8'h33);
        repeat (4) pop_and_check();            // three elements, then an empty pop.
    endtask

    task automatic round_robin_order();
        push_elem(1'b0, 8'ha0);
        push_elem(1'b0, 8'ha1);
        push_elem(1'b0, 8'ha2);
        push_elem(1'b1, 8'hb0);
        push_elem(1'b1, 8'hb1);
        repeat (5) pop_and_check();            // alternates, channel 0 serves the tail.
        push_elem(1'b1, 8'hb2);
        push_elem(1'b1, 8'hb3);
        repeat (2) pop_and_check();            // lone channel 1 served twice.
    endtask

    task automatic back_pressure();
        push_elem(1'b1, 8'hc0);
        push_elem(1'b1, 8'hc1);
        push_elem(1'b1, 8'hc2);
        push_elem(1'b1, 8'hc3);
        expect_eq("in1_ready_o", 32'd0, in1_ready);      // fifo full.
        expect_eq("in0_ready_o", 32'd1, in0_ready);
        pop_and_check();
        expect_eq("in1_ready_o", 32'd1, in1_ready);      // one slot free again.
        repeat (3) pop_and_check();
    endtask

    task automatic counter_clear();
        check_counts();
        wb_write(`COLL_ADR_COUNT, '0);
        cnt0 = '0;
        cnt1 = '0;
        check_counts();
        push_elem(1'b0, 8'h5a);
        pop_and_check();
        check_counts();                        // counting resumes after the clear.
    endtask

    task automatic random_traffic();
        int    i;
        int    r;
        data_t d;
        for (i = 0; i < 48; i++) begin
            r = $urandom % 3;
            d = data_t'($urandom);
            if (r == 0 && q0.size() < `COLL_DEPTH) push_elem(1'b0, d);
            else if (r == 1 && q1.size() < `COLL_DEPTH) push_elem(1'b1, d);
            else pop_and_check();
        end
        while (q0.size() != 0 || q1.size() != 0) pop_and_check();
        pop_and_check();                       // drained collector reads zero.
        check_counts();
    endtask

    // ***********************************************************
    // sequence and summary.
    // ***********************************************************
    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        in0_data     = '0;
        in0_valid    = 1'b0;
        in1_data     = '0;
        in1_valid    = 1'b0;
        wb_req       = '0;
        value_errs   = 0;
        timeout_errs = 0;
        void'($urandom(39));
        apply_reset();
        idle_after_reset();
        single_channel_order();
        apply_reset();                         // round robin starts from channel 0.
        round_robin_order();
        back_pressure();
        counter_clear();
        random_traffic();
        $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+rtl
rtl/coll_pkg.sv
rtl/fifo.sv
rtl/rr_stream_arbiter.sv
rtl/wb_pop_port.sv
rtl/stream_collector.sv
tb/tb_stream_collector.sv
